//--- design/spi_cmd_settings.svh
`ifndef SPI_CMD_SETTINGS_SVH
`define SPI_CMD_SETTINGS_SVH

// command word, flag + address + write data.
`define SPI_CMD_WIDTH 12

// read data returned from the slave.
`define SPI_READ_WIDTH 8

// clk cycles per sclk half period.
`define SPI_SCLK_HALF 4

// cs high time between read header and read data, in clk cycles.
`define SPI_READ_GAP 100

`endif

//--- design/spi_cmd_pkg.sv
`include "spi_cmd_settings.svh"

package spi_cmd_pkg;

  // header of a read frame is flag + address.
  localparam int SPI_HDR_BITS = `SPI_CMD_WIDTH - `SPI_READ_WIDTH;
  localparam int SPI_ADDR_BITS = SPI_HDR_BITS - 1;

  // bit 11 first, matches the raw command layout.
  typedef struct packed {
    logic                       is_write; // 1 write, 0 read.
    logic [SPI_ADDR_BITS-1:0]   addr;
    logic [`SPI_READ_WIDTH-1:0] wdata;
  } spi_cmd_t;

  // one request to the bit engine.
  typedef struct packed {
    logic [`SPI_CMD_WIDTH-1:0] tx_word; // left aligned, msb out first.
    logic [3:0]                nbits;   // 1 to 12.
  } spi_shift_req_t;

endpackage

//--- design/spi_cmd_capture.sv
`timescale 1ns/10ps
`include "spi_cmd_settings.svh"

module spi_cmd_capture (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`SPI_CMD_WIDTH-1:0] cmd_in,
  input  logic                      cmd_vld,
  output logic                      cmd_rdy,
  output spi_cmd_pkg::spi_cmd_t     cmd,
  output logic                      cmd_valid,
  input  logic                      cmd_take
);

  import spi_cmd_pkg::*;

  logic                      full;
  logic [`SPI_CMD_WIDTH-1:0] cmd_buf;
  logic                      accept;

  // ready only while the single slot is free.
  assign cmd_rdy = ~full;
  assign accept  = cmd_vld & cmd_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full <= 1'b0;
    end
    else if (accept)
    begin
      full <= 1'b1;
    end
    else if (cmd_take)
    begin
      full <= 1'b0; // sequencer has it now.
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_buf <= cmd_in;
    end
  end

  // raw word maps straight onto the struct.
  assign cmd       = spi_cmd_t'(cmd_buf);
  assign cmd_valid = full;

  // the sequencer may only take what is on offer.
  a_take_needs_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_take |-> cmd_valid
  ) else $error("cmd_take with no buffered command");

endmodule

//--- design/spi_frame_seq.sv
`timescale 1ns/10ps
`include "spi_cmd_settings.svh"

module spi_frame_seq (
  input  logic                        clk,
  input  logic                        rst_n,
  input  spi_cmd_pkg::spi_cmd_t       cmd,
  input  logic                        cmd_valid,
  output logic                        cmd_take,
  output spi_cmd_pkg::spi_shift_req_t shift_req,
  output logic                        shift_start,
  input  logic                        shift_done,
  input  logic [`SPI_READ_WIDTH-1:0]  rx_bits,
  output logic                        cs,
  output logic                        read_vld,
  output logic [`SPI_READ_WIDTH-1:0]  read_data
);

  import spi_cmd_pkg::*;

  localparam int GAP_W = $clog2(`SPI_READ_GAP + 1);
  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`SPI_READ_GAP - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_RD_HDR,
    ST_GAP,
    ST_RD_DATA
  } state_t;

  state_t           state;
  logic [GAP_W-1:0] gap_cnt;
  logic             gap_end;

  // take only when idle.
  assign cmd_take = (state == ST_IDLE) && cmd_valid;
  assign gap_end  = (state == ST_GAP) && (gap_cnt == GAP_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= ST_IDLE;
      cs          <= 1'b1;
      shift_start <= 1'b0;
      read_vld    <= 1'b0;
      gap_cnt     <= '0;
    end
    else
    begin
      shift_start <= 1'b0;
      read_vld    <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (cmd_valid)
          begin
            cs          <= 1'b0;
            shift_start <= 1'b1;
            state       <= cmd.is_write ? ST_WRITE : ST_RD_HDR;
          end
        end
        ST_WRITE:
        begin
          // cs back high first, idle one cycle later.
          if (shift_done)
            cs <= 1'b1;
          else if (cs)
            state <= ST_IDLE;
        end
        ST_RD_HDR:
        begin
          if (shift_done)
          begin
            cs      <= 1'b1;
            gap_cnt <= '0;
            state   <= ST_GAP;
          end
        end
        ST_GAP:
        begin
          if (gap_end)
          begin
            cs          <= 1'b0; // open the data frame.
            shift_start <= 1'b1;
            state       <= ST_RD_DATA;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        ST_RD_DATA:
        begin
          if (shift_done)
          begin
            cs       <= 1'b1;
            read_vld <= 1'b1;
          end
          else if (cs)
            state <= ST_IDLE;
        end
        default:
        begin
          state <= ST_IDLE;
          cs    <= 1'b1;
        end
      endcase
    end
  end

  // shift request and read result.
  always_ff @(posedge clk)
  begin
    if (cmd_take)
    begin
      if (cmd.is_write)
        shift_req <= '{tx_word: cmd, nbits: 4'(`SPI_CMD_WIDTH)};
      else
        shift_req <= '{tx_word: {cmd.is_write, cmd.addr, {`SPI_READ_WIDTH{1'b0}}},
                       nbits: 4'(SPI_HDR_BITS)};
    end
    else if (gap_end)
    begin
      shift_req <= '{tx_word: '0, nbits: 4'(`SPI_READ_WIDTH)}; // mosi held low.
    end
    if (state == ST_RD_DATA && shift_done)
      read_data <= rx_bits;
  end

  a_gap_cs_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == ST_RD_HDR && shift_done) |=> cs [*`SPI_READ_GAP]
  ) else $error("cs dropped during read gap");

  // every shift opens a frame in the same cycle.
  a_start_at_frame: assert property (
    @(posedge clk) disable iff (!rst_n)
    shift_start |-> $fell(cs)
  ) else $error("shift_start outside a frame start");

endmodule

//--- design/spi_bit_engine.sv
`timescale 1ns/10ps
`include "spi_cmd_settings.svh"

module spi_bit_engine (
  input  logic                        clk,
  input  logic                        rst_n,
  input  spi_cmd_pkg::spi_shift_req_t shift_req,
  input  logic                        shift_start,
  output logic                        shift_done,
  output logic [`SPI_READ_WIDTH-1:0]  rx_bits,
  output logic                        sclk,
  output logic                        mosi,
  input  logic                        miso
);

  import spi_cmd_pkg::*;

  localparam int TX_W   = `SPI_CMD_WIDTH;
  localparam int RX_W   = `SPI_READ_WIDTH;
  localparam int HALF_W = $clog2(`SPI_SCLK_HALF + 1);
  localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`SPI_SCLK_HALF - 1);

  logic              busy;
  logic [HALF_W-1:0] half_cnt;
  logic [3:0]        bit_cnt;   // bits still to go.
  logic [TX_W-1:0]   tx_sreg;
  logic [RX_W-1:0]   rx_sreg;
  logic              half_edge;

  // sclk flips on this cycle's edge.
  assign half_edge = busy && (half_cnt == HALF_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy       <= 1'b0;
      half_cnt   <= '0;
      bit_cnt    <= '0;
      sclk       <= 1'b0;
      mosi       <= 1'b0;
      shift_done <= 1'b0;
    end
    else
    begin
      shift_done <= 1'b0;
      if (shift_start)
      begin
        busy     <= 1'b1;
        half_cnt <= '0;
        bit_cnt  <= shift_req.nbits;
        sclk     <= 1'b0;
        mosi     <= shift_req.tx_word[TX_W-1]; // first bit right away.
      end
      else if (half_edge)
      begin
        half_cnt <= '0;
        sclk     <= ~sclk;
        if (sclk)
        begin
          // falling edge, next bit or finish.
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == 4'd1)
          begin
            busy       <= 1'b0;
            shift_done <= 1'b1;
            mosi       <= 1'b0;
          end
          else
            mosi <= tx_sreg[TX_W-2];
        end
      end
      else if (busy)
      begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // shift registers.
  always_ff @(posedge clk)
  begin
    if (shift_start)
    begin
      tx_sreg <= shift_req.tx_word;
      rx_sreg <= '0;
    end
    else if (half_edge)
    begin
      if (!sclk)
        rx_sreg <= {rx_sreg[RX_W-2:0], miso}; // rising edge sample.
      else
        tx_sreg <= {tx_sreg[TX_W-2:0], 1'b0};
    end
  end

  assign rx_bits = rx_sreg;

  a_no_start_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    shift_start |-> !busy
  ) else $error("shift_start while a shift is running");

endmodule

//--- design/spi_cmd_master.sv
`timescale 1ns/10ps
`include "spi_cmd_settings.svh"

module spi_cmd_master (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`SPI_CMD_WIDTH-1:0]  cmd_in,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  output logic                       sclk,
  output logic                       cs,
  output logic                       mosi,
  input  logic                       miso,
  output logic                       read_vld,
  output logic [`SPI_READ_WIDTH-1:0] read_data
);

  import spi_cmd_pkg::*;

  spi_cmd_t                   cmd;
  logic                       cmd_valid;
  logic                       cmd_take;
  spi_shift_req_t             shift_req;
  logic                       shift_start;
  logic                       shift_done;
  logic [`SPI_READ_WIDTH-1:0] rx_bits;

  // stage 1, one command of lookahead.
  spi_cmd_capture u_capture (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_take  (cmd_take)
  );

  spi_frame_seq u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .cmd_take    (cmd_take),
    .shift_req   (shift_req),
    .shift_start (shift_start),
    .shift_done  (shift_done),
    .rx_bits     (rx_bits),
    .cs          (cs),
    .read_vld    (read_vld),
    .read_data   (read_data)
  );

  spi_bit_engine u_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .shift_req   (shift_req),
    .shift_start (shift_start),
    .shift_done  (shift_done),
    .rx_bits     (rx_bits),
    .sclk        (sclk),
    .mosi        (mosi),
    .miso        (miso)
  );

endmodule

//--- dv/spi_slave_model.sv
`timescale 1ns/10ps
`include "spi_cmd_settings.svh"

module spi_slave_model (
  input  logic                      sclk,
  input  logic                      cs,
  input  logic                      mosi,
  output logic                      miso,
  output logic [`SPI_CMD_WIDTH-1:0] frame_word, // right aligned bits of the last frame.
  output logic [3:0]                frame_len,
  output time                       frame_gap,  // cs high time before the last frame.
  output int                        frame_cnt
);

  logic [`SPI_READ_WIDTH-1:0] regs [0:7];
  logic [`SPI_CMD_WIDTH-1:0]  rx_word;
  logic [3:0]                 rx_len;
  logic [`SPI_READ_WIDTH-1:0] tx_byte;
  logic [2:0]                 rd_addr;
  logic                       rd_pending;
  time                        cs_rise_time;

  initial
  begin
    logic cs_q;
    logic sclk_q;
    for (int i = 0; i < 8; i++)
      regs[i] = 8'(i * 37 + 11);
    miso         = 1'b0;
    frame_word   = '0;
    frame_len    = '0;
    frame_gap    = 0;
    frame_cnt    = 0;
    rx_word      = '0;
    rx_len       = '0;
    tx_byte      = '0;
    rd_addr      = '0;
    rd_pending   = 1'b0;
    cs_rise_time = 0;
    cs_q         = 1'b1;
    sclk_q       = 1'b0;
    forever
    begin
      @(cs or sclk);
      if (cs_q && !cs)
      begin
        // frame opens.
        frame_gap = $time - cs_rise_time;
        rx_word   = '0;
        rx_len    = '0;
        if (rd_pending)
        begin
          tx_byte = regs[rd_addr];
          miso    = tx_byte[`SPI_READ_WIDTH-1]; // first bit before the first rising edge.
        end
      end
      else if (!cs_q && cs && rx_len != 4'd0)
      begin
        frame_word   = rx_word;
        frame_len    = rx_len;
        frame_cnt    = frame_cnt + 1;
        cs_rise_time = $time;
        miso         = 1'b0;
        if (rx_len == 4'd12 && rx_word[11])
          regs[rx_word[10:8]] = rx_word[7:0];
        else if (rx_len == 4'd4 && !rx_word[3])
        begin
          rd_pending = 1'b1;
          rd_addr    = rx_word[2:0];
        end
        else if (rx_len == 4'd8)
          rd_pending = 1'b0; // data frame done.
      end
      if (!cs)
      begin
        if (!sclk_q && sclk)
        begin
          rx_word = {rx_word[`SPI_CMD_WIDTH-2:0], mosi};
          rx_len  = rx_len + 4'd1;
        end
        else if (sclk_q && !sclk)
        begin
          tx_byte = {tx_byte[`SPI_READ_WIDTH-2:0], 1'b0};
          miso    = tx_byte[`SPI_READ_WIDTH-1];
        end
      end
      cs_q   = cs;
      sclk_q = sclk;
    end
  end

endmodule

//--- dv/spi_cmd_master_tb.sv
`timescale 1ns/10ps
`include "spi_cmd_settings.svh"

module spi_cmd_master_tb;

  localparam int     N_CMDS     = 60;
  localparam int     CLK_NS     = 10;
  localparam time    MIN_GAP_NS = time'(`SPI_READ_GAP * CLK_NS);
  localparam longint LIMIT_NS   =
    longint'(2 * N_CMDS * (24 * `SPI_SCLK_HALF + `SPI_READ_GAP + 40) * CLK_NS);

  typedef struct packed {
    logic [`SPI_CMD_WIDTH-1:0] word;
    logic [3:0]                len;
  } frame_t;

  logic                       clk;
  logic                       rst_n;
  logic [`SPI_CMD_WIDTH-1:0]  cmd_in;
  logic                       cmd_vld;
  logic                       cmd_rdy;
  logic                       sclk;
  logic                       cs;
  logic                       mosi;
  logic                       miso;
  logic                       read_vld;
  logic [`SPI_READ_WIDTH-1:0] read_data;
  logic [`SPI_CMD_WIDTH-1:0]  frame_word;
  logic [3:0]                 frame_len;
  time                        frame_gap;
  int                         frame_cnt;

  int seed = 24;
  int frame_errs = 0;
  int read_errs = 0;
  int misc_errs = 0;

  // expected frames and reads, written by the stimulus, read by the monitor.
  logic [`SPI_READ_WIDTH-1:0] ref_regs [0:7];
  frame_t                     exp_frames [0:3*N_CMDS-1];
  logic [`SPI_READ_WIDTH-1:0] exp_reads [0:N_CMDS-1];
  int                         frame_wr = 0;
  int                         read_wr = 0;
  int                         frame_rd = 0;
  int                         read_rd = 0;

  spi_cmd_master dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model slave_i (
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso),
    .frame_word (frame_word),
    .frame_len  (frame_len),
    .frame_gap  (frame_gap),
    .frame_cnt  (frame_cnt)
  );

  initial clk = 1'b0;
  always #(CLK_NS / 2) clk = ~clk;

  // reference model, in accept order.
  task automatic record_accept(input logic [`SPI_CMD_WIDTH-1:0] c);
    if (c[11])
    begin
      exp_frames[frame_wr] = '{word: c, len: 4'd12};
      frame_wr             = frame_wr + 1;
      ref_regs[c[10:8]]    = c[7:0];
    end
    else
    begin
      exp_frames[frame_wr]     = '{word: {8'h00, c[11:8]}, len: 4'd4};
      exp_frames[frame_wr + 1] = '{word: '0, len: 4'd8}; // mosi low in data frame.
      frame_wr                 = frame_wr + 2;
      exp_reads[read_wr]       = ref_regs[c[10:8]];
      read_wr                  = read_wr + 1;
    end
  endtask

  task automatic send_cmd(input logic [`SPI_CMD_WIDTH-1:0] c);
    cmd_in  = c;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
      @(negedge clk);
    record_accept(c); // taken on the next rising edge.
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic check_reset_state();
    assert (cs && !sclk && !mosi && !read_vld && cmd_rdy)
    else
    begin
      misc_errs = misc_errs + 1;
      $display("FAIL %0t: after reset cs=%b sclk=%b mosi=%b read_vld=%b cmd_rdy=%b",
               $time, cs, sclk, mosi, read_vld, cmd_rdy);
    end
  endtask

  // frame and read monitor.
  always @(negedge clk)
  begin
    frame_t                     want;
    logic [`SPI_READ_WIDTH-1:0] want_rd;
    if (frame_cnt != frame_rd)
    begin
      assert (frame_rd < frame_wr)
      else
      begin
        frame_errs = frame_errs + 1;
        $display("%0t: the slave saw a frame that no command asked for", $time);
      end
      if (frame_rd < frame_wr)
      begin
        want = exp_frames[frame_rd];
        assert (frame_len == want.len && frame_word == want.word)
        else
        begin
          frame_errs = frame_errs + 1;
          $display("FAIL %0t: frame %h of %0d bits, expected %h of %0d bits",
                   $time, frame_word, frame_len, want.word, want.len);
        end
        if (want.len == 4'd8)
        begin
          assert (frame_gap >= MIN_GAP_NS)
          else
          begin
            frame_errs = frame_errs + 1;
            $display("FAIL %0t: read gap %0t, expected at least %0t",
                     $time, frame_gap, MIN_GAP_NS);
          end
        end
      end
      frame_rd = frame_rd + 1;
    end
    if (read_vld)
    begin
      assert (read_rd < read_wr)
      else
      begin
        read_errs = read_errs + 1;
        $display("%0t: read_vld pulsed with no read outstanding", $time);
      end
      if (read_rd < read_wr)
      begin
        want_rd = exp_reads[read_rd];
        assert (read_data == want_rd)
        else
        begin
          read_errs = read_errs + 1;
          $display("FAIL %0t: read_data %h, expected %h", $time, read_data, want_rd);
        end
      end
      read_rd = read_rd + 1;
    end
  end

  initial
  begin
    logic [`SPI_CMD_WIDTH-1:0] c;
    logic [1:0]                idle;
    for (int i = 0; i < 8; i++)
      ref_regs[i] = 8'(i * 37 + 11); // same start contents as the slave.
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    for (int n = 0; n < N_CMDS; n++)
    begin
      c = 12'($random(seed));
      send_cmd(c);
      idle = 2'($random(seed));
      repeat (idle) @(negedge clk);
    end
    // drain until every frame and read is seen and the pipeline is empty.
    while (frame_rd < frame_wr || read_rd < read_wr || !cmd_rdy || !cs)
      @(negedge clk);
    repeat (20) @(negedge clk);
    assert (read_rd == read_wr && frame_rd == frame_wr)
    else
    begin
      misc_errs = misc_errs + 1;
      $display("%0t: saw %0d reads and %0d frames, but %0d reads and %0d frames were sent",
               $time, read_rd, frame_rd, read_wr, frame_wr);
    end
    $display("errors: frames %0d, reads %0d, other %0d", frame_errs, read_errs, misc_errs);
    if (frame_errs == 0 && read_errs == 0 && misc_errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // watchdog.
  initial
  begin
    #(LIMIT_NS);
    $display("timeout: the run did not finish within %0d ns", LIMIT_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- spi_cmd_master.f
+incdir+design
design/spi_cmd_pkg.sv
design/spi_cmd_capture.sv
design/spi_frame_seq.sv
design/spi_bit_engine.sv
design/spi_cmd_master.sv
dv/spi_slave_model.sv
dv/spi_cmd_master_tb.sv

//--- Makefile
# Verilator build and run for the SPI command master.

VERILATOR ?= verilator
TB_TOP    ?= spi_cmd_master_tb
RTL_TOP   ?= spi_cmd_master
FILELIST  ?= spi_cmd_master.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTS PASSED
COMMON    ?= --timing --assert --timescale 1ns/10ps
VFLAGS    ?= --binary -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(COMMON) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(COMMON) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
